// File: Bender.yml
package:
  name: adpcmb

sources:
  # packages first, then rtl bottom up
  - wb_pkg.sv
  - adpcmb_pkg.sv
  - adpcmb_fifo.sv
  - adpcmb_wb_regs.sv
  - adpcmb_nibble_feed.sv
  - adpcmb_decoder.sv
  - adpcmb_top.sv
  - target: simulation
    files:
      - adpcmb_props.sv
      - tb_adpcmb.sv

// File: adpcmb_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcmb_decoder: five stage adpcm-b sample decoder
// step scaled offset, sign, accumulate, saturate, step adapt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              chon,
    input  logic              adv,        // start one decode
    input  adpcmb_pkg::code_t code,
    output adpcmb_pkg::pcm_t  pcm,
    output logic              pcm_valid,
    output logic              busy
);
    import adpcmb_pkg::*;

    pcm_t        x1;           // last sample
    step_t       step1;        // current step
    logic [3:0]  d2;           // magnitude * 2 + 1
    logic        sign_data;    // held for stages 3 and 5
    logic [15:0] d3;           // offset magnitude
    logic [15:0] d4;           // signed offset
    logic [16:0] next_step3;   // unclamped step
    pcm_t        next_x5;      // unsaturated sum
    logic [7:0]  step_mul;
    logic [18:0] off_prod;     // 4 x 15 bits
    logic [22:0] step_prod;    // 8 x 15 bits
    logic [4:0]  vld;          // one bit per stage

    always_comb begin
        // d2[3:1] is the magnitude, small ones share the first entry
        if (d2[3]) step_mul = STEP_MUL[d2[2:1] + 3'd1];
        else       step_mul = STEP_MUL[0];
        off_prod  = d2 * step1;
        step_prod = step_mul * step1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) vld <= '0;
        else if (!chon) vld <= '0;   // in-flight decode abandoned
        else vld <= {vld[3:0], adv};
    end

    // datapath, only one sample in flight so stages may read x1 and sign_data directly
    always_ff @(posedge clk) begin
        if (adv) begin                 // 1 latch the code
            d2        <= {code[2:0], 1'b1};
            sign_data <= code[3];
        end
        d3         <= off_prod[18:3];  // 2 divide by 8
        next_step3 <= step_prod[22:6]; //   divide by 64
        d4         <= sign_data ? ~d3 + 16'd1 : d3;   // 3 two's complement
        next_x5    <= x1 + d4;         // 4 accumulate, wraps
    end

    // 5 saturate and adapt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1    <= '0;
            step1 <= STEP_MIN;
        end else if (!chon) begin
            x1    <= '0;
            step1 <= STEP_MIN;
        end else if (vld[3]) begin
            // same sign added and the sum flipped sign, so it overflowed
            if (sign_data == x1[15] && x1[15] != next_x5[15])
                x1 <= x1[15] ? PCM_MIN : PCM_MAX;
            else
                x1 <= next_x5;
            if (next_step3 < 17'(STEP_MIN))      step1 <= STEP_MIN;
            else if (next_step3 > 17'(STEP_MAX)) step1 <= STEP_MAX;
            else                                 step1 <= next_step3[14:0];
        end
    end

    assign pcm       = x1;
    assign pcm_valid = vld[4] & chon;   // chon may drop on the update edge
    assign busy      = |vld;            // includes the pcm_valid cycle

endmodule

`default_nettype wire

// File: adpcmb_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcmb_fifo: synchronous circular buffer, any payload type
// head entry falls through to pop_data, clr empties it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clr,        // synchronous flush
    input  logic       push,
    input  payload_t   push_data,
    input  logic       pop,
    output payload_t   pop_data,
    output logic       full,
    output logic       empty,
    output logic [3:0] count
);
    import adpcmb_pkg::*;

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push & ~full;   // push on full dropped
    assign do_pop  = pop & ~empty;   // pop on empty dropped

    assign full     = (count == 4'(FIFO_DEPTH));
    assign empty    = (count == 4'd0);
    assign pop_data = mem[rd_ptr];   // first word fall through

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + 4'(do_push) - 4'(do_pop);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: adpcmb_nibble_feed.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcmb_nibble_feed: byte to nibble splitter
// one decode in flight, high nibble first, stalls on full output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_nibble_feed (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              chon,
    input  logic              byte_empty,
    input  adpcmb_pkg::byte_t byte_head,
    output logic              byte_pop,
    input  logic              busy,       // decoder still working
    input  logic              pcm_full,   // no room for the next sample
    output logic              adv,
    output adpcmb_pkg::code_t code
);
    import adpcmb_pkg::*;

    logic  half;      // low nibble of a popped byte still pending
    code_t low_nib;
    logic  ready;

    // the previous sample must be settled before the next decode
    assign ready = chon & ~busy & ~pcm_full;

    assign adv      = ready & (half | ~byte_empty);
    assign byte_pop = ready & ~half & ~byte_empty;   // byte leaves with its high nibble
    assign code     = half ? low_nib : byte_head[7:4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half <= 1'b0;
        end else if (!chon) begin
            half <= 1'b0;   // half used byte dropped
        end else if (adv) begin
            half <= ~half;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_pop) low_nib <= byte_head[3:0];
    end

endmodule

`default_nettype wire

// File: adpcmb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcm-b codec definitions
// sample and step types, limits, multiplier table, register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package adpcmb_pkg;

    typedef logic signed [15:0] pcm_t;   // decoded sample
    typedef logic [14:0]        step_t;  // adaptive step size
    typedef logic [3:0]         code_t;  // bit 3 sign, bits 2..0 magnitude
    typedef logic [7:0]         byte_t;  // two codes, high nibble first

    // step limits, STEP_MIN is also the idle value
    localparam step_t STEP_MIN = 15'd127;
    localparam step_t STEP_MAX = 15'd24576;

    localparam pcm_t PCM_MAX = 16'sh7fff;
    localparam pcm_t PCM_MIN = 16'sh8000;

    // entry 0 for magnitudes 0..3, then 4, 5, 6, 7
    localparam logic [7:0] STEP_MUL [5] = '{8'd57, 8'd77, 8'd102, 8'd128, 8'd153};

    // both fifos
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // register map, word addresses
    localparam logic [1:0] REG_CTRL   = 2'd0;  // bit 0 chon
    localparam logic [1:0] REG_DATA   = 2'd1;  // write pushes low byte
    localparam logic [1:0] REG_PCM    = 2'd2;  // read pops one sample
    localparam logic [1:0] REG_STATUS = 2'd3;  // read only

    // status word, read back in bits 9..0
    typedef struct packed {
        logic       chon;
        logic [3:0] in_count;   // bytes waiting
        logic [3:0] out_count;  // samples ready
        logic       busy;       // decode in flight
    } status_t;

endpackage

`default_nettype wire

// File: adpcmb_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcm-b handshake assertions
// bus ack and decoder pipeline checks bound into the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_props (
    input logic            clk,
    input logic            rst_n,
    input wb_pkg::wb_req_t bus_req,
    input wb_pkg::wb_rsp_t bus_rsp,
    input logic            chon,
    input logic            adv,
    input logic            busy,
    input logic            pcm_valid
);
    // classic ack only inside an active cycle
    ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.ack |-> (bus_req.cyc && bus_req.stb))
        else $error("ack seen without cyc and stb");

    // decode latency holds unless the channel drops on the way
    decode_latency: assert property (@(posedge clk) disable iff (!rst_n)
        adv ##1 chon [*5] |-> pcm_valid)
        else $error("pcm_valid not 5 cycles after adv");

    // decoder busy covers the whole pipeline so no second decode starts
    no_adv_busy: assert property (@(posedge clk) disable iff (!rst_n)
        adv |=> !adv [*5])
        else $error("adv issued while decoder busy");

    // an abandoned decode never surfaces, even once chon is back
    no_valid_off: assert property (@(posedge clk) disable iff (!rst_n)
        !chon |-> !pcm_valid [*6])
        else $error("pcm_valid while channel off");

endmodule

bind adpcmb_top adpcmb_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .chon      (chon),
    .adv       (adv),
    .busy      (busy),
    .pcm_valid (pcm_valid)
);

`default_nettype wire

// File: adpcmb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcmb_top: single channel adpcm-b playback block
// wishbone slave, byte fifo, nibble feeder, decoder, pcm fifo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_top (
    input  logic            clk,
    input  logic            rst_n,
    input  wb_pkg::wb_req_t bus_req,
    output wb_pkg::wb_rsp_t bus_rsp
);
    import adpcmb_pkg::*;

    logic       chon;
    // byte side
    logic       byte_push;
    byte_t      byte_data;
    logic       byte_full;
    logic       byte_empty;
    byte_t      byte_head;
    logic       byte_pop;
    logic [3:0] in_count;
    // sample side
    logic       pcm_pop;
    logic       pcm_full;
    logic       pcm_empty;
    pcm_t       pcm_head;
    logic [3:0] out_count;
    // feeder to decoder
    logic       adv;
    code_t      code;
    pcm_t       pcm;
    logic       pcm_valid;
    logic       busy;

    adpcmb_wb_regs u_wb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .byte_full (byte_full),
        .pcm_empty (pcm_empty),
        .busy      (busy),
        .pcm_head  (pcm_head),
        .in_count  (in_count),
        .out_count (out_count),
        .chon      (chon),
        .byte_push (byte_push),
        .byte_data (byte_data),
        .pcm_pop   (pcm_pop)
    );

    adpcmb_fifo #(.payload_t(byte_t)) u_byte_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (~chon),   // flushed while the channel is off
        .push      (byte_push),
        .push_data (byte_data),
        .pop       (byte_pop),
        .pop_data  (byte_head),
        .full      (byte_full),
        .empty     (byte_empty),
        .count     (in_count)
    );

    adpcmb_nibble_feed u_nibble_feed (
        .clk        (clk),
        .rst_n      (rst_n),
        .chon       (chon),
        .byte_empty (byte_empty),
        .byte_head  (byte_head),
        .byte_pop   (byte_pop),
        .busy       (busy),
        .pcm_full   (pcm_full),
        .adv        (adv),
        .code       (code)
    );

    adpcmb_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .chon      (chon),
        .adv       (adv),
        .code      (code),
        .pcm       (pcm),
        .pcm_valid (pcm_valid),
        .busy      (busy)
    );

    adpcmb_fifo #(.payload_t(pcm_t)) u_pcm_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (~chon),
        .push      (pcm_valid),
        .push_data (pcm),
        .pop       (pcm_pop),
        .pop_data  (pcm_head),
        .full      (pcm_full),
        .empty     (pcm_empty),
        .count     (out_count)
    );

endmodule

`default_nettype wire

// File: adpcmb_wb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcmb_wb_regs: wishbone classic slave for the adpcm-b block
// control bit, byte push, sample pop and status readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adpcmb_wb_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::wb_req_t   bus_req,
    output wb_pkg::wb_rsp_t   bus_rsp,
    input  logic              byte_full,  // byte fifo cannot take a write
    input  logic              pcm_empty,
    input  logic              busy,       // decoder activity
    input  adpcmb_pkg::pcm_t  pcm_head,   // pcm fifo head
    input  logic [3:0]        in_count,
    input  logic [3:0]        out_count,
    output logic              chon,
    output logic              byte_push,
    output adpcmb_pkg::byte_t byte_data,
    output logic              pcm_pop
);
    import adpcmb_pkg::*;

    logic        req;       // request not yet acked
    logic        wr_data;   // data register write
    logic        take;      // request accepted this cycle
    logic        ack_q;
    logic [31:0] dat_q;
    logic [31:0] rd_data;
    status_t     status;

    // the acking cycle itself never counts as a new request
    assign req     = bus_req.cyc & bus_req.stb & ~ack_q;
    assign wr_data = bus_req.we & (bus_req.adr == REG_DATA);
    assign take    = req & ~(wr_data & byte_full);  // wait states while byte fifo full

    assign byte_push = take & wr_data;
    assign byte_data = bus_req.dat[7:0];
    // an empty pcm fifo reads as zero and pops nothing
    assign pcm_pop   = take & ~bus_req.we & (bus_req.adr == REG_PCM) & ~pcm_empty;

    assign status = '{chon: chon, in_count: in_count, out_count: out_count, busy: busy};

    always_comb begin
        rd_data = '0;   // unused bits and REG_DATA read as zero
        case (bus_req.adr)
            REG_CTRL:   rd_data[0] = chon;
            REG_PCM: begin
                if (!pcm_empty) rd_data = {{16{pcm_head[15]}}, pcm_head};  // sign extend
            end
            REG_STATUS: rd_data[$bits(status_t)-1:0] = status;
            default:    rd_data = '0;
        endcase
    end

    // ack and control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            chon  <= 1'b0;
        end else begin
            ack_q <= take;   // one cycle after the request is taken
            if (take && bus_req.we && bus_req.adr == REG_CTRL) chon <= bus_req.dat[0];
        end
    end

    // read data captured with the pop, fifo head is current here
    always_ff @(posedge clk) begin
        if (take && !bus_req.we) dat_q <= rd_data;
    end

    assign bus_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// File: sim.f
wb_pkg.sv
adpcmb_pkg.sv
adpcmb_fifo.sv
adpcmb_wb_regs.sv
adpcmb_nibble_feed.sv
adpcmb_decoder.sv
adpcmb_top.sv
adpcmb_props.sv
tb_adpcmb.sv

// File: tb_adpcmb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// adpcm-b playback block testbench
// random byte stream against a decode model plus bus corner cases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_adpcmb;
    import adpcmb_pkg::*;
    import wb_pkg::*;

    localparam int WAIT_LIMIT = 200;   // cycles per bus transfer
    localparam int POLL_LIMIT = 300;   // status polls per drain

    logic        clk;
    logic        rst_n;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;

    logic [31:0] rng;          // xorshift state
    pcm_t        m_pcm;        // model sample
    int          m_step;       // model step
    pcm_t        expq [$];     // samples still to be read
    int          n_checks;
    int          n_errors;
    int          n_timeouts;
    logic        saw_max;
    logic        saw_min;

    adpcmb_top u_adpcmb_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s did not complete in time at %0d ns", what, $time);
        n_timeouts++;
        finish_run();
    endtask

    task automatic check_pcm(input pcm_t got, input pcm_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %0d ns: %s status got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one classic transfer with the request held until ack is seen
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk);
        bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bus_rsp.ack && n < WAIT_LIMIT);
        if (!bus_rsp.ack) begin
            timeout_fail("bus transfer");
        end else begin
            rdat = bus_rsp.dat;
            @(negedge clk);   // ack sampled at the edge before this
            bus_req = '0;
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic model_reset();
        m_pcm  = '0;
        m_step = 127;
        expq.delete();
    endtask

    // decode rule in 16-bit sample arithmetic
    task automatic model_nibble(input code_t c);
        int          prod;
        logic [15:0] off;
        pcm_t        sum;
        int          mul;
        int          nstep;
        prod = (2 * int'(c[2:0]) + 1) * m_step;
        off  = 16'(prod >> 3);
        if (c[3]) off = ~off + 16'd1;   // sign bit set
        sum = m_pcm + pcm_t'(off);
        if (c[3] == m_pcm[15] && sum[15] != m_pcm[15])
            sum = m_pcm[15] ? 16'sh8000 : 16'sh7fff;   // overflow holds at the rail
        case (c[2:0])
            3'd4:    mul = 77;
            3'd5:    mul = 102;
            3'd6:    mul = 128;
            3'd7:    mul = 153;
            default: mul = 57;
        endcase
        nstep = (m_step * mul) >> 6;
        if (nstep < 127)   nstep = 127;
        if (nstep > 24576) nstep = 24576;
        m_pcm  = sum;
        m_step = nstep;
        expq.push_back(sum);
    endtask

    task automatic send_byte(input byte_t b);
        model_nibble(b[7:4]);   // high nibble decodes first
        model_nibble(b[3:0]);
        wb_write(REG_DATA, {24'd0, b});
    endtask

    // read every sample the status says is ready
    task automatic pop_ready();
        logic [31:0] rd;
        status_t     st;
        wb_read(REG_STATUS, rd);
        st = rd[$bits(status_t)-1:0];
        repeat (st.out_count) begin
            wb_read(REG_PCM, rd);
            if (rd[31:16] !== {16{rd[15]}}) begin
                n_errors++;
                $display("[ERROR] %0d ns: pcm read %h not sign extended", $time, rd);
            end
            if (rd[15:0] == 16'h7fff) saw_max = 1'b1;
            if (rd[15:0] == 16'h8000) saw_min = 1'b1;
            if (expq.size() == 0) begin
                n_errors++;
                $display("[ERROR] %0d ns: sample %h read with none expected", $time, rd);
            end else begin
                check_pcm(pcm_t'(rd[15:0]), expq.pop_front(), "pcm sample");
            end
        end
    endtask

    task automatic drain_all(input string what);
        int n;
        n = 0;
        while (expq.size() != 0 && n < POLL_LIMIT) begin
            pop_ready();
            n++;
        end
        if (expq.size() != 0) timeout_fail(what);
    endtask

    task automatic send_random(input int count);
        repeat (count) begin
            rng = xorshift32(rng);
            send_byte(rng[7:0]);
            pop_ready();
        end
    endtask

    task automatic restart_channel();
        wb_write(REG_CTRL, 32'd0);   // clears fifos and decoder state
        model_reset();
        wb_write(REG_CTRL, 32'd1);
    endtask

    initial begin
        logic [31:0] rd;
        status_t     st;
        int          n;
        bus_req    = '0;
        rst_n      = 1'b0;
        rng        = 32'h0dcaacbc;
        n_checks   = 0;
        n_errors   = 0;
        n_timeouts = 0;
        saw_max    = 1'b0;
        saw_min    = 1'b0;
        model_reset();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        wb_read(REG_STATUS, rd);
        check_status(rd[9:0], '0, "after reset");
        wb_write(REG_CTRL, 32'd1);
        wb_read(REG_PCM, rd);
        check_pcm(pcm_t'(rd[15:0]), '0, "empty pcm read");

        // random stream
        send_random(200);
        drain_all("random stream drain");

        // saturation from a fresh channel
        restart_channel();
        saw_max = 1'b0;
        saw_min = 1'b0;
        repeat (12) begin
            send_byte(8'h77);
            pop_ready();
        end
        drain_all("positive run drain");
        repeat (12) begin
            send_byte(8'hff);
            pop_ready();
        end
        drain_all("negative run drain");
        if (!saw_max || !saw_min) begin
            n_errors++;
            $display("saturation run never reached both sample limits");
        end

        // step clamping through small, large and then random codes
        restart_channel();
        repeat (8) begin
            send_byte(8'h00);
            pop_ready();
        end
        repeat (8) begin
            send_byte(8'h77);
            pop_ready();
        end
        send_random(40);
        drain_all("step clamp drain");

        // channel off in the middle of a stream
        repeat (6) begin
            rng = xorshift32(rng);
            send_byte(rng[7:0]);
        end
        wb_write(REG_CTRL, 32'd0);
        wb_read(REG_STATUS, rd);
        check_status(rd[9:0], '0, "channel off");
        model_reset();   // pending samples are gone
        wb_write(REG_CTRL, 32'd1);
        send_random(20);
        drain_all("after restart drain");

        // bus corner cases
        wb_read(REG_PCM, rd);
        check_pcm(pcm_t'(rd[15:0]), '0, "empty pcm read");
        repeat (FIFO_DEPTH + 4) begin   // back-pressure fills both fifos when nothing is read
            rng = xorshift32(rng);
            send_byte(rng[7:0]);
        end
        n = 0;
        do begin
            wb_read(REG_STATUS, rd);
            st = rd[9:0];
            n++;
        end while (st.out_count != 4'(FIFO_DEPTH) && n < POLL_LIMIT);
        if (st.out_count != 4'(FIFO_DEPTH)) begin
            timeout_fail("pcm fifo fill");
        end else begin
            check_status(st, '{chon: 1'b1, in_count: 4'(FIFO_DEPTH),
                               out_count: 4'(FIFO_DEPTH), busy: 1'b0}, "both fifos full");
        end
        drain_all("back-pressure drain");

        finish_run();
    end

endmodule

`default_nettype wire

// File: wb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic bus types
// request and response bundles for the register slave
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package wb_pkg;

    // master to slave, held until ack
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;   // word address, four registers
        logic [31:0] dat;   // write data
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;   // one cycle per transfer
        logic [31:0] dat;   // read data, valid with ack
    } wb_rsp_t;

endpackage

`default_nettype wire
